// File: common/counter_pkg.sv
package counter_pkg;

    ///////////////////////////////////////////////////////////////////////
    // sizes and rates
    ///////////////////////////////////////////////////////////////////////

    localparam int num_digits = 4;                       // ones .. thousands

    // rate divider base, limit = tick_base >> speed
    localparam logic [31:0] tick_base = 32'd100_000_000; // one second at 100 MHz

    // refresh counter width, digit advances on each wrap
    localparam int scan_div_bits = 17;

    ///////////////////////////////////////////////////////////////////////
    // modes and selections
    ///////////////////////////////////////////////////////////////////////

    // wrap point per digit
    typedef enum logic
    {
        mode_decimal = 1'b0,  // wraps at 9
        mode_hex     = 1'b1   // wraps at 15
    } count_mode_t;

    typedef enum logic
    {
        dir_up   = 1'b0,
        dir_down = 1'b1
    } count_dir_t;

    // which digit the scan is showing
    typedef enum logic [1:0]
    {
        digit_ones      = 2'd0,
        digit_tens      = 2'd1,
        digit_hundreds  = 2'd2,
        digit_thousands = 2'd3
    } digit_sel_t;

endpackage

// File: counter/count_digit.sv
module count_digit
    import counter_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  count_mode_t digit_mode,
    input  count_dir_t  digit_dir,
    input  logic        step,         // advance one count this edge
    input  logic        load_digits,  // take load_num this edge
    input  logic [3:0]  load_num,
    output logic [3:0]  count,
    output logic        at_limit      // next step carries into the digit above
);

    logic [3:0] max_val;    // 9 or 15 by mode
    logic [3:0] load_val;   // load_num after decimal clamp
    logic [3:0] next_up;
    logic [3:0] next_down;

    assign max_val = (digit_mode == mode_hex) ? 4'd15 : 4'd9;

    // decimal loads above 9 are held at 9
    assign load_val = (digit_mode == mode_decimal && load_num > 4'd9) ? 4'd9 : load_num;

    //////////////////////////////////////////////////////////////////////
    // next values
    //////////////////////////////////////////////////////////////////////

    // up: anything at or past the wrap point goes back to 0
    assign next_up = (count >= max_val) ? 4'd0 : count + 4'd1;

    // down: 0 wraps to the top, stray decimal values just decrement
    assign next_down = (count == 4'd0) ? max_val : count - 4'd1;

    // carry condition follows direction
    assign at_limit = (digit_dir == dir_up) ? (count >= max_val)   // >9 in decimal carries too
                                            : (count == 4'd0);

    //////////////////////////////////////////////////////////////////////
    // digit register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            count <= 4'd0;
        end
        else if (load_digits)
        begin
            count <= load_val;             // load has priority
        end
        else if (step)
        begin
            if (digit_dir == dir_up)
            begin
                count <= next_up;
            end
            else
            begin
                count <= next_down;
            end
        end
    end

    // decimal load never leaves a non decimal digit behind
    a_dec_load_clamp: assert property (@(posedge clk) disable iff (reset)
        (load_digits && digit_mode == mode_decimal) |=> (count <= 4'd9));

endmodule

// File: counter_display_top.f
common/counter_pkg.sv
display/seg_decoder.sv
display/display_scan.sv
counter/count_digit.sv
src/counter_control.sv
src/counter_display_top.sv
sim/tb_counter_display.sv

// File: display/display_scan.sv
module display_scan
    import counter_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] ones,
    input  logic [3:0] tens,
    input  logic [3:0] hundreds,
    input  logic [3:0] thousands,
    output logic [7:0] an,        // active low, upper four stay dark
    output logic [6:0] sseg       // active low, bit 0 is segment a
);

    logic [scan_div_bits-1:0] refresh_cnt;  // free running
    logic                     refresh_wrap; // last count before wrap
    digit_sel_t               sel_q;        // digit being shown
    logic [3:0]               shown;        // value of that digit

    //////////////////////////////////////////////////////////////////////
    // refresh counter and digit select
    //////////////////////////////////////////////////////////////////////

    assign refresh_wrap = &refresh_cnt;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            refresh_cnt <= '0;
            sel_q       <= digit_ones;
        end
        else
        begin
            refresh_cnt <= refresh_cnt + 1'b1;
            if (refresh_wrap)
            begin
                sel_q <= digit_sel_t'(sel_q + 2'd1);  // thousands rolls to ones
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // digit mux and anode drive
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (sel_q)
            digit_ones:      begin shown = ones;      an = 8'b1111_1110; end
            digit_tens:      begin shown = tens;      an = 8'b1111_1101; end
            digit_hundreds:  begin shown = hundreds;  an = 8'b1111_1011; end
            digit_thousands: begin shown = thousands; an = 8'b1111_0111; end
            default:         begin shown = 4'd0;      an = 8'b1111_1111; end
        endcase
    end

    seg_decoder u_seg_decoder
    (
        .digit (shown),
        .sseg  (sseg)
    );

    // one lit anode among the low four, never the upper ones
    a_one_anode: assert property (@(posedge clk) disable iff (reset)
        (an[7:4] == 4'hf) && $onehot(~an[3:0]));

endmodule

// File: display/seg_decoder.sv
module seg_decoder
(
    input  logic [3:0] digit,   // one hex digit
    output logic [6:0] sseg     // {g,f,e,d,c,b,a}, low lights a segment
);

    // hex glyph table
    always_comb
    begin
        case (digit)
            4'h0:    sseg = 7'b100_0000;
            4'h1:    sseg = 7'b111_1001;  // b c
            4'h2:    sseg = 7'b010_0100;
            4'h3:    sseg = 7'b011_0000;
            4'h4:    sseg = 7'b001_1001;
            4'h5:    sseg = 7'b001_0010;
            4'h6:    sseg = 7'b000_0010;
            4'h7:    sseg = 7'b111_1000;  // a b c
            4'h8:    sseg = 7'b000_0000;  // all on
            4'h9:    sseg = 7'b001_0000;

            // letters, b and d in lower case so they differ from 8 and 0
            4'ha:    sseg = 7'b000_1000;
            4'hb:    sseg = 7'b000_0011;
            4'hc:    sseg = 7'b100_0110;
            4'hd:    sseg = 7'b010_0001;
            4'he:    sseg = 7'b000_0110;
            4'hf:    sseg = 7'b000_1110;
            default: sseg = 7'b111_1111;  // blank on unknown input
        endcase
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the counter display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f counter_display_top.f \
    --top-module tb_counter_display \
    -o tb_counter_display
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/tb_counter_display)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Simulation PASSED"; then
    exit 0
else
    exit 1
fi

// File: sim/tb_counter_display.sv
module tb_counter_display
    import counter_pkg::*;
();

    // ten display readouts of about 524k cycles each plus margin
    localparam int max_cycles = 8_000_000;

    logic       clk;
    logic       reset;
    logic       mode;
    logic       enable;
    logic       direction;
    logic       load;
    logic [3:0] load_num;
    logic [4:0] speed;
    logic [6:0] sseg;
    logic [7:0] an;

    int          error_count = 0;
    int          cycle_count = 0;
    int          model_value;           // display value as a plain number
    count_mode_t model_mode;            // mode the DUT has registered
    logic [7:0]  anode_seq [num_digits];  // anode patterns of the last readout

    counter_display_top dut_i
    (
        .clk       (clk),
        .reset     (reset),
        .mode      (mode),
        .enable    (enable),
        .direction (direction),
        .load      (load),
        .load_num  (load_num),
        .speed     (speed),
        .sseg      (sseg),
        .an        (an)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("%0d errors", error_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // every digit takes the same value clamped to 9 in decimal
    function automatic void model_load(input logic [3:0] v);
        int d;
        d = int'(v);
        if (model_mode == mode_decimal && d > 9)
        begin
            d = 9;
        end
        model_value = (model_mode == mode_decimal) ? d * 1111 : d * 32'h1111;
    endfunction

    // n steps of the whole four digit number
    function automatic void model_count(input int n, input count_dir_t d);
        int base;
        base = (model_mode == mode_decimal) ? 10000 : 65536;
        if (d == dir_up)
        begin
            model_value = (model_value + n) % base;
        end
        else
        begin
            model_value = (model_value + base - (n % base)) % base;
        end
    endfunction

    function automatic logic [15:0] model_digits();
        logic [15:0] v;
        int          rest;
        v = 16'h0;
        if (model_mode == mode_hex)
        begin
            v = model_value[15:0];
        end
        else
        begin
            rest = model_value;
            for (int i = 0; i < num_digits; i++)
            begin
                v[i*4 +: 4] = 4'(rest % 10);   // bcd digit
                rest        = rest / 10;
            end
        end
        return v;
    endfunction

    // {g..a} pattern with low lit segments to hex value or -1
    function automatic int glyph_value(input logic [6:0] pattern);
        case (pattern)
            7'b100_0000: return 0;
            7'b111_1001: return 1;
            7'b010_0100: return 2;
            7'b011_0000: return 3;
            7'b001_1001: return 4;
            7'b001_0010: return 5;
            7'b000_0010: return 6;
            7'b111_1000: return 7;
            7'b000_0000: return 8;
            7'b001_0000: return 9;
            7'b000_1000: return 10;   // A
            7'b000_0011: return 11;   // b
            7'b100_0110: return 12;   // C
            7'b010_0001: return 13;   // d
            7'b000_0110: return 14;   // E
            7'b000_1110: return 15;   // F
            default:     return -1;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and display reader
    //////////////////////////////////////////////////////////////////////

    task automatic check_digits(input string name, input logic [15:0] actual,
                                input logic [15:0] expected);
        if (actual !== expected)
        begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_anodes(input string name, input logic [7:0] actual,
                                input logic [7:0] expected);
        if (actual !== expected)
        begin
            $display("error at %0t: %s is %b, expected %b", $time, name, actual, expected);
            error_count++;
        end
    endtask

    // one full scan over four anode changes
    task automatic read_display(output logic [15:0] digits);
        int value;
        digits = 16'h0;
        for (int i = 0; i < num_digits; i++)
        begin
            @(an);              // next digit lit
            @(negedge clk);     // sample mid cycle
            anode_seq[i] = an;
            value = glyph_value(sseg);
            if (value < 0)
            begin
                $display("at %0t the segments show %b, which is not a hex glyph",
                         $time, sseg);
                error_count++;
                value = 0;
            end
            case (an)
                8'b1111_1110: digits[3:0]   = 4'(value);
                8'b1111_1101: digits[7:4]   = 4'(value);
                8'b1111_1011: digits[11:8]  = 4'(value);
                8'b1111_0111: digits[15:12] = 4'(value);
                default:
                begin
                    $display("at %0t the anodes %b do not select a single digit",
                             $time, an);
                    error_count++;
                end
            endcase
        end
    endtask

    task automatic verify_display(input string name);
        logic [15:0] got;
        read_display(got);
        check_digits(name, got, model_digits());
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic set_controls(input count_mode_t m, input count_dir_t d,
                                input logic [4:0] s);
        @(posedge clk);
        mode       <= m;
        direction  <= d;
        speed      <= s;
        model_mode = m;
        @(posedge clk);     // DUT registers mode and direction here
    endtask

    task automatic load_value(input logic [3:0] v);
        @(posedge clk);
        load     <= 1'b1;
        load_num <= v;
        @(posedge clk);
        load     <= 1'b0;
        model_load(v);
    endtask

    // enable sampled high at exactly n edges
    task automatic run_enabled(input int n);
        @(posedge clk);
        enable <= 1'b1;
        repeat (n) @(posedge clk);
        enable <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        logic [15:0] got;
        @(negedge clk);
        check_anodes("an after reset", an, 8'b1111_1110);
        read_display(got);
        check_digits("display after reset", got, 16'h0000);
        check_anodes("an scan 1", anode_seq[0], 8'b1111_1101);   // tens
        check_anodes("an scan 2", anode_seq[1], 8'b1111_1011);
        check_anodes("an scan 3", anode_seq[2], 8'b1111_0111);
        check_anodes("an scan 4", anode_seq[3], 8'b1111_1110);   // back to ones
    endtask

    task automatic test_load();
        logic [3:0] r;
        set_controls(mode_hex, dir_up, 5'd31);
        load_value(4'd12);
        verify_display("hex load of 12");
        set_controls(mode_decimal, dir_up, 5'd31);
        load_value(4'd12);
        verify_display("decimal load of 12");   // clamped
        r = 4'($urandom % 10);
        load_value(r);
        verify_display("random decimal load");

        // load and enable together while the counter ticks every cycle
        r = 4'((int'(r) + 1 + int'($urandom % 9)) % 10);
        @(posedge clk);
        load     <= 1'b1;
        enable   <= 1'b1;
        load_num <= r;
        repeat (5) @(posedge clk);
        load   <= 1'b0;
        enable <= 1'b0;
        model_load(r);
        verify_display("load held with enable");
    endtask

    task automatic test_count_up_decimal();
        logic [3:0] r;
        int         n;
        set_controls(mode_decimal, dir_up, 5'd31);
        r = 4'($urandom % 10);
        n = 1 + int'($urandom % 400);
        load_value(r);
        run_enabled(n);
        model_count(n, dir_up);
        verify_display("decimal count up");

        load_value(4'd9);       // 9999
        run_enabled(3);
        model_count(3, dir_up);
        verify_display("decimal carry through 9999");
    endtask

    task automatic test_count_down_hex();
        int n;
        set_controls(mode_hex, dir_down, 5'd31);
        load_value(4'd0);
        n = 1 + int'($urandom % 300);
        run_enabled(n);
        model_count(n, dir_down);
        verify_display("hex count down");
    endtask

    task automatic test_rate_and_hold();
        logic [3:0] r;
        int         k;
        int         period;
        period = 96;   // limit 95 at speed 20 gives a tick every 96 cycles
        set_controls(mode_decimal, dir_up, 5'd20);
        r = 4'($urandom % 10);
        load_value(r);
        k = 1 + int'($urandom % 4);
        run_enabled(period * k);
        model_count(k, dir_up);
        verify_display("count at speed 20");

        // fast ticks but enable low
        set_controls(mode_decimal, dir_up, 5'd31);
        repeat (5000) @(posedge clk);
        verify_display("count held with enable low");
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(32'hfd135c49));
        model_value = 0;
        model_mode  = mode_decimal;
        reset       = 1'b1;
        mode        = 1'b0;
        enable      = 1'b0;
        direction   = 1'b0;
        load        = 1'b0;
        load_num    = 4'd0;
        speed       = 5'd0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        test_reset();
        test_load();
        test_count_up_decimal();
        test_count_down_hex();
        test_rate_and_hold();

        $display("%0d errors in %0d cycles", error_count, cycle_count);
        if (error_count == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: src/counter_control.sv
module counter_control
    import counter_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  count_mode_t           mode,        // decimal or hex
    input  logic                  enable,      // count while high
    input  count_dir_t            direction,   // up or down
    input  logic                  load,        // load strobe, any edge
    input  logic [4:0]            speed,       // rate setting, 31 is fastest
    input  logic [num_digits-1:0] at_limit,    // per digit carry out
    output logic [num_digits-1:0] step,        // per digit step strobe
    output logic                  load_digits, // load strobe to all digits
    output count_mode_t           digit_mode,
    output count_dir_t            digit_dir
);

    logic [31:0] div_cnt;   // rate divider
    logic [31:0] limit;     // terminal value for the current speed
    logic        tick;      // one cycle pace pulse
    logic        carry;     // running carry through the chain
    count_mode_t mode_q;
    count_dir_t  dir_q;

    //////////////////////////////////////////////////////////////////////
    // rate divider
    //////////////////////////////////////////////////////////////////////

    assign limit = tick_base >> speed;   // speed 31 gives 0, tick every cycle
    assign tick  = (div_cnt >= limit);   // >= so a speed change never overshoots

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div_cnt <= '0;
        end
        else if (tick)
        begin
            div_cnt <= '0;               // restart after the tick cycle
        end
        else
        begin
            div_cnt <= div_cnt + 32'd1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // mode and direction, registered once for all digits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            mode_q <= mode_decimal;
            dir_q  <= dir_up;
        end
        else
        begin
            mode_q <= mode;
            dir_q  <= direction;
        end
    end

    assign digit_mode = mode_q;
    assign digit_dir  = dir_q;

    //////////////////////////////////////////////////////////////////////
    // step chain
    //////////////////////////////////////////////////////////////////////

    // digit k steps when every lower digit sits at its limit
    always_comb
    begin
        carry = 1'b1;                           // ones digit has no lower digit
        for (int k = 0; k < num_digits; k++)
        begin
            step[k] = tick & enable & ~load & carry;   // load beats step
            carry   = carry & at_limit[k];
        end
    end

    assign load_digits = load;   // loads do not wait for a tick

    // steps only come with the pace pulse
    a_step_needs_tick: assert property (@(posedge clk) disable iff (reset)
        (|step) |-> tick);

    // carries ripple from the ones digit upward, never skip a digit
    generate
        for (genvar k = 1; k < num_digits; k++)
        begin : g_chain_chk
            a_step_chain: assert property (@(posedge clk) disable iff (reset)
                step[k] |-> step[k-1]);
        end
    endgenerate

    a_no_step_on_load: assert property (@(posedge clk) disable iff (reset)
        !((|step) && load_digits));

endmodule

// File: src/counter_display_top.sv
module counter_display_top
    import counter_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       mode,       // 0 decimal, 1 hex
    input  logic       enable,
    input  logic       direction,  // 0 up, 1 down
    input  logic       load,
    input  logic [3:0] load_num,
    input  logic [4:0] speed,
    output logic [6:0] sseg,
    output logic [7:0] an
);

    logic [num_digits-1:0] step;         // per digit step strobes
    logic [num_digits-1:0] at_limit;     // per digit carries
    logic                  load_digits;
    count_mode_t           digit_mode;
    count_dir_t            digit_dir;
    logic [3:0]            count [num_digits];  // index 0 is ones

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    counter_control u_counter_control
    (
        .clk         (clk),
        .reset       (reset),
        .mode        (count_mode_t'(mode)),
        .enable      (enable),
        .direction   (count_dir_t'(direction)),
        .load        (load),
        .speed       (speed),
        .at_limit    (at_limit),
        .step        (step),
        .load_digits (load_digits),
        .digit_mode  (digit_mode),
        .digit_dir   (digit_dir)
    );

    //////////////////////////////////////////////////////////////////////
    // digits
    //////////////////////////////////////////////////////////////////////

    generate
        for (genvar k = 0; k < num_digits; k++)
        begin : g_digit
            count_digit u_count_digit
            (
                .clk         (clk),
                .reset       (reset),
                .digit_mode  (digit_mode),
                .digit_dir   (digit_dir),
                .step        (step[k]),
                .load_digits (load_digits),
                .load_num    (load_num),   // same value into every digit
                .count       (count[k]),
                .at_limit    (at_limit[k])
            );
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // display
    //////////////////////////////////////////////////////////////////////

    display_scan u_display_scan
    (
        .clk       (clk),
        .reset     (reset),
        .ones      (count[0]),
        .tens      (count[1]),
        .hundreds  (count[2]),
        .thousands (count[3]),
        .an        (an),
        .sseg      (sseg)
    );

endmodule
